/* hw/shell_cfg_pkg.sv */
package shell_cfg_pkg;

	localparam logic [3:0] ADDR_CFG = 4'h0;
	localparam logic [3:0] ADDR_ID = 4'h4;
	localparam logic [31:0] SHELL_ID = 32'h5348_4c31;  // ASCII "SHL1"
	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef struct packed {
		logic [25:0] rsvd_hi;
		logic scandoubler_disable;
		logic [1:0] scanlines;  // Quarters dimmed, 0 is off
		logic rotate;  // 0 selects the rotated mapping
		logic rsvd_lo;
		logic soft_reset;
	} cfg_fields_t;

	typedef union packed {
		logic [31:0] raw;
		cfg_fields_t fields;
	} cfg_word_t;

	typedef struct packed {
		logic [3:0] awaddr;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
		logic [3:0] araddr;
		logic arvalid;
		logic rready;
	} axil_req_t;

	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		logic [1:0] bresp;
		logic arready;
		logic rvalid;
		logic [31:0] rdata;
		logic [1:0] rresp;
	} axil_rsp_t;

endpackage

/* hw/shell_io_pkg.sv */
package shell_io_pkg;

	typedef struct packed {
		logic strobe;
		logic pressed;
		logic [7:0] code;  // PS/2 set 2 scan code
	} key_event_t;

	typedef struct packed {
		logic [2:0] unused;
		logic fire;
		logic up;
		logic down;
		logic left;
		logic right;  // Bit 0
	} joy_t;

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire;
		logic coin;
		logic start1;
		logic start2;
	} player_ctrl_t;

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [1:0] b;
		logic hs;
		logic vs;
		logic blank_n;
	} core_pixel_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic hs;
		logic vs;
	} vga_pixel_t;

endpackage

/* hw/cfg_regs_axil.sv */
`timescale 1ns/10ps

module cfg_regs_axil #(
	parameter int ADDR_W = 4
) (
	input logic clock_24,
	input logic rst_n,
	input shell_cfg_pkg::axil_req_t axil_req,
	output shell_cfg_pkg::axil_rsp_t axil_rsp,
	output shell_cfg_pkg::cfg_word_t cfg,
	output logic core_reset
);
	import shell_cfg_pkg::*;

	cfg_word_t cfg_q;
	logic [31:0] wr_merged;
	logic [31:0] rd_word;
	logic [31:0] rdata_q;
	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;
	logic bvalid_q;
	logic rvalid_q;
	logic wr_fire;
	logic rd_fire;

	assign wr_addr = axil_req.awaddr[ADDR_W-1:0];
	assign rd_addr = axil_req.araddr[ADDR_W-1:0];
	assign wr_fire = axil_req.awvalid & axil_req.wvalid & ~bvalid_q;  // Address and data together
	assign rd_fire = axil_req.arvalid & ~rvalid_q;

	always_comb begin
		wr_merged = cfg_q.raw;
		for (int i = 0; i < 4; i++) begin
			if (axil_req.wstrb[i]) begin
				wr_merged[8*i +: 8] = axil_req.wdata[8*i +: 8];
			end
		end
	end

	always_comb begin
		if (rd_addr == ADDR_CFG[ADDR_W-1:0]) begin
			rd_word = cfg_q.raw;
		end else if (rd_addr == ADDR_ID[ADDR_W-1:0]) begin
			rd_word = SHELL_ID;
		end else begin
			rd_word = '0;  // Unmapped
		end
	end

	always_ff @(posedge clock_24 or negedge rst_n) begin
		if (!rst_n) begin
			cfg_q <= '0;
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			rdata_q <= '0;
		end else begin
			if (wr_fire && wr_addr == ADDR_CFG[ADDR_W-1:0]) begin
				cfg_q.raw <= wr_merged;
			end
			if (wr_fire) begin
				bvalid_q <= 1'b1;
			end else if (axil_req.bready) begin
				bvalid_q <= 1'b0;
			end
			if (rd_fire) begin
				rvalid_q <= 1'b1;
				rdata_q <= rd_word;
			end else if (axil_req.rready) begin
				rvalid_q <= 1'b0;
			end
		end
	end

	always_comb begin
		axil_rsp.awready = wr_fire;
		axil_rsp.wready = wr_fire;
		axil_rsp.bvalid = bvalid_q;
		axil_rsp.bresp = RESP_OKAY;
		axil_rsp.arready = ~rvalid_q;  // Blocked while a read is pending
		axil_rsp.rvalid = rvalid_q;
		axil_rsp.rdata = rdata_q;
		axil_rsp.rresp = RESP_OKAY;
	end

	assign cfg = cfg_q;
	assign core_reset = ~rst_n | cfg_q.fields.soft_reset;  // One reset for the core

endmodule

/* hw/key_decoder.sv */
`timescale 1ns/10ps

module key_decoder (
	input logic clock_24,
	input logic rst_n,
	input shell_io_pkg::key_event_t key,
	output shell_io_pkg::player_ctrl_t keys
);

	// Each mapped key keeps its last pressed or released state
	always_ff @(posedge clock_24 or negedge rst_n) begin
		if (!rst_n) begin
			keys <= '0;
		end else if (key.strobe) begin
			case (key.code)
				8'h75: keys.up <= key.pressed;  // Cursor up
				8'h72: keys.down <= key.pressed;  // Cursor down
				8'h6B: keys.left <= key.pressed;  // Cursor left
				8'h74: keys.right <= key.pressed;  // Cursor right
				8'h76: keys.coin <= key.pressed;  // Esc
				8'h05: keys.start1 <= key.pressed;  // F1
				8'h06: keys.start2 <= key.pressed;  // F2
				8'h29: keys.fire <= key.pressed;  // Space
				default: ;
			endcase
		end
	end

endmodule

/* hw/control_mapper.sv */
`timescale 1ns/10ps

module control_mapper (
	input shell_io_pkg::player_ctrl_t keys,
	input shell_io_pkg::joy_t joy_0,
	input shell_io_pkg::joy_t joy_1,
	input shell_cfg_pkg::cfg_word_t cfg,
	output shell_io_pkg::player_ctrl_t ctrl
);

	logic up_any;
	logic down_any;
	logic left_any;
	logic right_any;

	assign up_any = keys.up | joy_0.up | joy_1.up;
	assign down_any = keys.down | joy_0.down | joy_1.down;
	assign left_any = keys.left | joy_0.left | joy_1.left;
	assign right_any = keys.right | joy_0.right | joy_1.right;

	always_comb begin
		ctrl = keys;  // Coin and starts pass through
		ctrl.fire = keys.fire | joy_0.fire | joy_1.fire;
		if (!cfg.fields.rotate) begin
			// Monitor turned on its side
			ctrl.up = left_any;
			ctrl.down = right_any;
			ctrl.left = down_any;
			ctrl.right = up_any;
		end else begin
			ctrl.up = up_any;
			ctrl.down = down_any;
			ctrl.left = left_any;
			ctrl.right = right_any;
		end
	end

endmodule

/* hw/video_shaper.sv */
`timescale 1ns/10ps

module video_shaper (
	input logic clock_24,
	input logic rst_n,
	input shell_io_pkg::core_pixel_t pix_in,
	input shell_cfg_pkg::cfg_word_t cfg,
	output shell_io_pkg::vga_pixel_t pix_out
);
	import shell_io_pkg::*;

	vga_pixel_t pix_next;
	logic [2:0] b_wide;
	logic hs_prev;
	logic vs_prev;
	logic odd_line;
	logic dim_en;

	// Takes away n quarters of c, each shifted term rounded down
	function automatic logic [5:0] dim(input logic [5:0] c, input logic [1:0] n);
		case (n)
			2'd1: dim = c - {2'b00, c[5:2]};
			2'd2: dim = c - {1'b0, c[5:1]};
			2'd3: dim = c - {1'b0, c[5:1]} - {2'b00, c[5:2]};
			default: dim = c;
		endcase
	endfunction

	assign b_wide = {pix_in.b, pix_in.b[1]};
	assign dim_en = odd_line & (cfg.fields.scanlines != 2'd0) & ~cfg.fields.scandoubler_disable;

	always_comb begin
		pix_next.hs = pix_in.hs;
		pix_next.vs = pix_in.vs;
		if (pix_in.blank_n) begin
			pix_next.r = {pix_in.r, pix_in.r};
			pix_next.g = {pix_in.g, pix_in.g};
			pix_next.b = {b_wide, b_wide};
		end else begin
			pix_next.r = '0;
			pix_next.g = '0;
			pix_next.b = '0;
		end
		if (dim_en) begin
			pix_next.r = dim(pix_next.r, cfg.fields.scanlines);
			pix_next.g = dim(pix_next.g, cfg.fields.scanlines);
			pix_next.b = dim(pix_next.b, cfg.fields.scanlines);
		end
	end

	always_ff @(posedge clock_24 or negedge rst_n) begin
		if (!rst_n) begin
			hs_prev <= 1'b0;
			vs_prev <= 1'b0;
			odd_line <= 1'b0;
			pix_out <= '0;
		end else begin
			hs_prev <= pix_in.hs;
			vs_prev <= pix_in.vs;
			if (pix_in.vs && !vs_prev) begin
				odd_line <= 1'b0;  // New frame starts even
			end else if (!pix_in.hs && hs_prev) begin
				odd_line <= ~odd_line;
			end
			pix_out <= pix_next;
		end
	end

endmodule

/* hw/sigma_delta_dac.sv */
`timescale 1ns/10ps

module sigma_delta_dac #(
	parameter int DAC_W = 16
) (
	input logic clock_24,
	input logic rst_n,
	input logic [15:0] sample,
	output logic audio_out
);

	logic [15:0] offset_bin;
	logic [DAC_W-1:0] level;
	logic [DAC_W-1:0] acc;
	logic [DAC_W:0] sum;

	assign offset_bin = {~sample[15], sample[14:0]};  // Signed to offset binary
	assign level = offset_bin[15 -: DAC_W];  // Top bits if narrower
	assign sum = {1'b0, acc} + {1'b0, level};

	always_ff @(posedge clock_24 or negedge rst_n) begin
		if (!rst_n) begin
			acc <= '0;
			audio_out <= 1'b0;
		end else begin
			acc <= sum[DAC_W-1:0];
			audio_out <= sum[DAC_W];  // Carry is the pulse
		end
	end

endmodule

/* hw/arcade_shell_top.sv */
`timescale 1ns/10ps

module arcade_shell_top #(
	parameter int ADDR_W = 4,
	parameter int DAC_W = 16
) (
	input logic clock_24,
	input logic rst_n,
	input shell_cfg_pkg::axil_req_t axil_req,
	output shell_cfg_pkg::axil_rsp_t axil_rsp,
	input shell_io_pkg::key_event_t key,
	input shell_io_pkg::joy_t joy_0,
	input shell_io_pkg::joy_t joy_1,
	input shell_io_pkg::core_pixel_t core_pix,
	input logic [15:0] core_audio,
	output shell_io_pkg::player_ctrl_t ctrl,
	output logic core_reset,
	output shell_io_pkg::vga_pixel_t vga,
	output logic audio_out
);
	import shell_cfg_pkg::*;
	import shell_io_pkg::*;

	cfg_word_t cfg;
	player_ctrl_t keys;  // Keyboard state before merging

	cfg_regs_axil #(
		.ADDR_W(ADDR_W)
	) i_cfg_regs (
		.clock_24(clock_24),
		.rst_n(rst_n),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.cfg(cfg),
		.core_reset(core_reset)
	);

	key_decoder i_key_decoder (
		.clock_24(clock_24),
		.rst_n(rst_n),
		.key(key),
		.keys(keys)
	);

	control_mapper i_control_mapper (
		.keys(keys),
		.joy_0(joy_0),
		.joy_1(joy_1),
		.cfg(cfg),
		.ctrl(ctrl)
	);

	video_shaper i_video_shaper (
		.clock_24(clock_24),
		.rst_n(rst_n),
		.pix_in(core_pix),
		.cfg(cfg),
		.pix_out(vga)
	);

	sigma_delta_dac #(
		.DAC_W(DAC_W)
	) i_dac (
		.clock_24(clock_24),
		.rst_n(rst_n),
		.sample(core_audio),
		.audio_out(audio_out)
	);

endmodule

/* verif/arcade_shell_tb.sv */
`timescale 1ns/10ps

module arcade_shell_tb;
	import shell_cfg_pkg::*;
	import shell_io_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int N_VEC = 22;
	localparam int WATCHDOG_CYCLES = N_VEC * 20 + 3000;

	typedef struct packed {
		logic [31:0] cfg;
		key_event_t key;
		joy_t joy_0;
		joy_t joy_1;
		core_pixel_t pix;
		player_ctrl_t ctrl;  // Expected controls
	} vec_t;

	logic clock_24 = 1'b0;
	logic rst_n;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	key_event_t key;
	joy_t joy_0;
	joy_t joy_1;
	core_pixel_t core_pix;
	logic [15:0] core_audio;
	player_ctrl_t ctrl;
	logic core_reset;
	vga_pixel_t vga;
	logic audio_out;

	vec_t tbl [N_VEC];
	vec_t v;
	vga_pixel_t exp_vga;
	core_pixel_t prev_pix;
	logic line_odd;  // Line parity model
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic [31:0] rnd;
	int err_cnt = 0;
	int n_errors = 0;
	int n_tests = 0;
	int n_failed = 0;

	arcade_shell_top #(
		.ADDR_W(4),
		.DAC_W(16)
	) i_dut (.*);

	always #(CLK_PERIOD / 2) clock_24 = ~clock_24;

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

	task automatic finish_test(input string name);
		n_tests++;
		if (err_cnt == 0) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, err_cnt);
			n_failed++;
			n_errors += err_cnt;
		end
		err_cnt = 0;
	endtask

	function automatic logic [5:0] lose_quarters(input logic [5:0] c, input logic [1:0] q);
		return c - (q[1] ? c >> 1 : 6'd0) - (q[0] ? c >> 2 : 6'd0);
	endfunction

	function automatic vga_pixel_t shape_pixel(input core_pixel_t p, input logic [31:0] cfg_w,
			input logic odd);
		vga_pixel_t o;
		logic [2:0] b3;
		b3 = {p.b, p.b[1]};
		o.hs = p.hs;
		o.vs = p.vs;
		o.r = p.blank_n ? {p.r, p.r} : 6'd0;
		o.g = p.blank_n ? {p.g, p.g} : 6'd0;
		o.b = p.blank_n ? {b3, b3} : 6'd0;
		if (odd && cfg_w[4:3] != 2'd0 && !cfg_w[5]) begin
			o.r = lose_quarters(o.r, cfg_w[4:3]);
			o.g = lose_quarters(o.g, cfg_w[4:3]);
			o.b = lose_quarters(o.b, cfg_w[4:3]);
		end
		return o;
	endfunction

	// hold is the number of cycles bready stays low
	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
			input logic [3:0] strb, input int hold);
		int n;
		@(posedge clock_24);
		axil_req.awaddr <= addr;
		axil_req.wdata <= data;
		axil_req.wstrb <= strb;
		axil_req.awvalid <= 1'b1;
		axil_req.wvalid <= 1'b1;
		axil_req.bready <= (hold == 0);
		n = 0;
		do begin
			@(negedge clock_24);
			n++;
		end while (!axil_rsp.awready && n < 20);
		if (!axil_rsp.awready || !axil_rsp.wready) begin
			$display("Write to address %h was never accepted", addr);
			err_cnt++;
		end
		@(posedge clock_24);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid <= 1'b0;
		repeat (hold + 1) begin
			@(negedge clock_24);
			if (!axil_rsp.bvalid) begin
				$display("Write response to address %h dropped before bready", addr);
				err_cnt++;
			end
		end
		check("bresp", {30'd0, axil_rsp.bresp}, 32'h0);
		@(posedge clock_24);
		axil_req.bready <= 1'b1;
		@(posedge clock_24);
		axil_req.bready <= 1'b0;
		@(negedge clock_24);
		if (axil_rsp.bvalid) begin
			$display("Write response stayed valid after bready");
			err_cnt++;
		end
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		@(posedge clock_24);
		axil_req.araddr <= addr;
		axil_req.arvalid <= 1'b1;
		axil_req.rready <= 1'b1;
		n = 0;
		do begin
			@(negedge clock_24);
			n++;
		end while (!axil_rsp.arready && n < 20);
		@(posedge clock_24);
		axil_req.arvalid <= 1'b0;
		@(negedge clock_24);
		if (!axil_rsp.rvalid) begin
			$display("Read from address %h got no response", addr);
			err_cnt++;
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
		@(posedge clock_24);
		axil_req.rready <= 1'b0;
	endtask

	task automatic dac_run(input logic [15:0] s);
		logic [15:0] lvl;
		int ones;
		int expect_ones;
		int diff;
		lvl = {~s[15], s[14:0]};
		expect_ones = int'((32'(lvl) * 1024) / 65536);
		ones = 0;
		@(posedge clock_24);
		core_audio <= s;
		@(posedge clock_24);
		repeat (1024) begin
			@(negedge clock_24);
			if (audio_out) begin
				ones++;
			end
		end
		diff = ones - expect_ones;
		if (diff > 1 || diff < -1) begin
			$display("Fail audio_out count: got %h expected %h", ones, expect_ones);
			err_cnt++;
		end
		finish_test($sformatf("dac sample %h", s));
	endtask

	initial begin
		rst_n <= 1'b0;
		axil_req <= '0;
		key <= '0;
		joy_0 <= '0;
		joy_1 <= '0;
		core_pix <= '{3'd7, 3'd7, 2'd3, 1'b0, 1'b0, 1'b1};  // Visible pixel during reset
		core_audio <= '0;
		prev_pix = '0;
		line_odd = 1'b0;
		rnd = $urandom(32'h918ac429);
		// cfg, key event, joy_0, joy_1, core pixel {r, g, b, hs, vs, blank_n}, ctrl
		tbl[0] = '{32'h04, 10'h375, 8'h00, 8'h00, '{3'd7, 3'd0, 2'd3, 1'b1, 1'b0, 1'b1}, 8'h80};
		tbl[1] = '{32'h04, 10'h275, 8'h00, 8'h00, '{3'd1, 3'd2, 2'd1, 1'b1, 1'b0, 1'b1}, 8'h00};
		tbl[2] = '{32'h04, 10'h376, 8'h00, 8'h00, '{3'd3, 3'd5, 2'd2, 1'b0, 1'b0, 1'b1}, 8'h04};
		tbl[3] = '{32'h0C, 10'h305, 8'h00, 8'h00, '{3'd7, 3'd7, 2'd3, 1'b1, 1'b0, 1'b1}, 8'h06};
		tbl[4] = '{32'h14, 10'h306, 8'h00, 8'h00, '{3'd5, 3'd3, 2'd1, 1'b1, 1'b0, 1'b1}, 8'h07};
		tbl[5] = '{32'h1C, 10'h276, 8'h00, 8'h00, '{3'd6, 3'd1, 2'd2, 1'b1, 1'b0, 1'b1}, 8'h03};
		tbl[6] = '{32'h3C, 10'h3AA, 8'h00, 8'h00, '{3'd7, 3'd7, 2'd3, 1'b1, 1'b0, 1'b1}, 8'h03};
		tbl[7] = '{32'h1C, 10'h329, 8'h00, 8'h00, '{3'd7, 3'd7, 2'd3, 1'b1, 1'b0, 1'b0}, 8'h0B};
		tbl[8] = '{32'h1C, 10'h205, 8'h00, 8'h00, '{3'd2, 3'd4, 2'd1, 1'b0, 1'b0, 1'b1}, 8'h09};
		tbl[9] = '{32'h1C, 10'h206, 8'h00, 8'h00, '{3'd7, 3'd7, 2'd3, 1'b1, 1'b0, 1'b1}, 8'h08};
		tbl[10] = '{32'h1C, 10'h229, 8'h00, 8'h00, '{3'd7, 3'd7, 2'd3, 1'b0, 1'b1, 1'b1}, 8'h00};
		tbl[11] = '{32'h00, 10'h36B, 8'h00, 8'h00, '{3'd1, 3'd1, 2'd1, 1'b0, 1'b0, 1'b1}, 8'h80};
		tbl[12] = '{32'h00, 10'h26B, 8'h08, 8'h00, '{3'd4, 3'd2, 2'd0, 1'b1, 1'b0, 1'b1}, 8'h10};
		tbl[13] = '{32'h00, 10'h000, 8'h00, 8'h04, '{3'd3, 3'd3, 2'd3, 1'b0, 1'b0, 1'b1}, 8'h20};
		tbl[14] = '{32'h10, 10'h000, 8'h01, 8'h02, '{3'd7, 3'd5, 2'd3, 1'b1, 1'b0, 1'b1}, 8'hC0};
		tbl[15] = '{32'h10, 10'h000, 8'h10, 8'h00, '{3'd6, 3'd6, 2'd2, 1'b1, 1'b0, 1'b1}, 8'h08};
		tbl[16] = '{32'h04, 10'h000, 8'h08, 8'h01, '{3'd5, 3'd5, 2'd1, 1'b1, 1'b0, 1'b1}, 8'h90};
		tbl[17] = '{32'h04, 10'h000, 8'h04, 8'h12, '{3'd0, 3'd7, 2'd0, 1'b0, 1'b0, 1'b0}, 8'h68};
		tbl[18] = '{32'h04, 10'h374, 8'h00, 8'h00, '{3'd2, 3'd2, 2'd2, 1'b1, 1'b0, 1'b1}, 8'h10};
		tbl[19] = '{32'h04, 10'h372, 8'h00, 8'h00, '{3'd3, 3'd6, 2'd1, 1'b1, 1'b0, 1'b1}, 8'h50};
		tbl[20] = '{32'h04, 10'h274, 8'h00, 8'h00, '{3'd7, 3'd0, 2'd0, 1'b0, 1'b0, 1'b1}, 8'h40};
		tbl[21] = '{32'h04, 10'h272, 8'hE0, 8'h00, '{3'd1, 3'd7, 2'd3, 1'b1, 1'b0, 1'b1}, 8'h00};

		repeat (4) @(posedge clock_24);
		@(negedge clock_24);
		check("core_reset", {31'd0, core_reset}, 32'h1);
		check("vga", {12'd0, vga}, 32'h0);
		check("audio_out", {31'd0, audio_out}, 32'h0);
		check("bvalid", {31'd0, axil_rsp.bvalid}, 32'h0);
		check("rvalid", {31'd0, axil_rsp.rvalid}, 32'h0);
		check("arready", {31'd0, axil_rsp.arready}, 32'h1);
		@(posedge clock_24);
		rst_n <= 1'b1;
		core_pix <= '0;
		@(negedge clock_24);
		check("core_reset", {31'd0, core_reset}, 32'h0);
		finish_test("reset");

		axil_write(ADDR_CFG, 32'hFFFF_FF3C, 4'hF, 0);
		axil_read(ADDR_CFG, rdata, rresp);
		check("rdata", rdata, 32'hFFFF_FF3C);
		axil_write(ADDR_CFG, 32'h0000_0000, 4'b0001, 0);
		axil_read(ADDR_CFG, rdata, rresp);
		check("rdata", rdata, 32'hFFFF_FF00);
		axil_write(ADDR_CFG, 32'h1234_56FF, 4'b1110, 3);  // Slow master on B
		axil_read(ADDR_CFG, rdata, rresp);
		check("rdata", rdata, 32'h1234_5600);
		finish_test("config register");

		axil_read(ADDR_ID, rdata, rresp);
		check("rdata", rdata, SHELL_ID);
		check("rresp", {30'd0, rresp}, 32'h0);
		axil_read(4'h8, rdata, rresp);
		check("rdata", rdata, 32'h0);
		check("rresp", {30'd0, rresp}, 32'h0);
		axil_write(4'hC, 32'hFFFF_FFFF, 4'hF, 0);
		axil_read(ADDR_CFG, rdata, rresp);
		check("rdata", rdata, 32'h1234_5600);
		finish_test("id and unmapped");

		for (int i = 0; i < N_VEC; i++) begin
			v = tbl[i];
			axil_write(ADDR_CFG, v.cfg, 4'hF, 0);
			@(posedge clock_24);
			key <= v.key;
			joy_0 <= v.joy_0;
			joy_1 <= v.joy_1;
			core_pix <= v.pix;
			@(posedge clock_24);
			key <= '0;  // One-cycle strobe
			exp_vga = shape_pixel(v.pix, v.cfg, line_odd);
			if (v.pix.vs && !prev_pix.vs) begin
				line_odd = 1'b0;
			end else if (!v.pix.hs && prev_pix.hs) begin
				line_odd = ~line_odd;
			end
			prev_pix = v.pix;
			@(negedge clock_24);
			check("ctrl", {24'd0, ctrl}, {24'd0, v.ctrl});
			check("vga", {12'd0, vga}, {12'd0, exp_vga});
			finish_test($sformatf("vector %0d", i));
		end

		axil_write(ADDR_CFG, 32'h1, 4'hF, 0);
		check("core_reset", {31'd0, core_reset}, 32'h1);
		axil_write(ADDR_CFG, 32'h0, 4'hF, 0);
		check("core_reset", {31'd0, core_reset}, 32'h0);
		finish_test("soft reset");

		for (int i = 0; i < 2; i++) begin
			rnd = $urandom;
			dac_run(rnd[15:0]);
		end

		$display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, n_errors);
		if (n_failed == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* filelist.f */
hw/shell_cfg_pkg.sv
hw/shell_io_pkg.sv
hw/cfg_regs_axil.sv
hw/key_decoder.sv
hw/control_mapper.sv
hw/video_shaper.sv
hw/sigma_delta_dac.sv
hw/arcade_shell_top.sv
verif/arcade_shell_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= arcade_shell_tb
FILELIST ?= filelist.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS ?= --binary --timing -j 0
PASS_MSG = TESTBENCH PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
